// ==== Bender.yml ====
package:
  name: rename_unit

sources:
  - files:
      - hw/rename_pkg.sv
      - hw/rename_map.sv
      - hw/free_list.sv
      - hw/ready_table.sv
      - hw/rename_unit.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_rename_unit.sv

// ==== hw/free_list.sv ====
// ##################################################
// free physical register pool, speculative and
// committed bitmaps with lowest-index allocation
// ##################################################

module free_list (
    input  logic                                         clock,
    input  logic                                         reset,
    input  logic                                         flush,
    input  logic                  [rename_pkg::WAYS-1:0] want,
    input  logic                  [rename_pkg::WAYS-1:0] fire,
    input  rename_pkg::commit_t   [rename_pkg::WAYS-1:0] commit,
    input  rename_pkg::phys_reg_t [rename_pkg::WAYS-1:0] released_phys,
    output rename_pkg::phys_reg_t [rename_pkg::WAYS-1:0] alloc_phys,
    output logic                                         has_room
);

    rename_pkg::phys_mask_t spec_free;
    rename_pkg::phys_mask_t comm_free;
    rename_pkg::phys_mask_t spec_next;
    rename_pkg::phys_mask_t comm_next;
    rename_pkg::phys_mask_t avail;      // pool left after older ways picked

    logic [rename_pkg::WAYS-1:0] found;

    // priority pick, one lowest free index per way
    always_comb begin
        avail = spec_free;
        for (int w = 0; w < rename_pkg::WAYS; w++) begin
            alloc_phys[w] = '0;
            found[w]      = 1'b0;
            // descending scan so the lowest hit lands last
            for (int p = rename_pkg::PHYS_REGS - 1; p >= 0; p--) begin
                if (avail[p]) begin
                    alloc_phys[w] = rename_pkg::phys_reg_t'(p);
                    found[w]      = 1'b1;
                end
            end
            // only enabled ways consume an entry
            if (want[w]) begin
                avail[alloc_phys[w]] = 1'b0;
            end
        end
    end

    // every enabled way found a register
    assign has_room = &(found | ~want);

    always_comb begin
        spec_next = spec_free;
        comm_next = comm_free;
        for (int w = 0; w < rename_pkg::WAYS; w++) begin
            if (fire[w]) begin
                spec_next[alloc_phys[w]] = 1'b0;
            end
        end
        // in order, so a same-arch pair releases way 0's phys correctly
        for (int c = 0; c < rename_pkg::WAYS; c++) begin
            if (commit[c].en) begin
                comm_next[commit[c].phys]   = 1'b0;   // now architectural
                comm_next[released_phys[c]] = 1'b1;
                spec_next[released_phys[c]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // registers above the identity map start free
            spec_free <= {rename_pkg::PHYS_REGS{1'b1}} << rename_pkg::ARCH_REGS;
            comm_free <= {rename_pkg::PHYS_REGS{1'b1}} << rename_pkg::ARCH_REGS;
        end else begin
            comm_free <= comm_next;
            if (flush) begin
                spec_free <= comm_next;
            end else begin
                spec_free <= spec_next;
            end
        end
    end

    for (genvar w = 0; w < rename_pkg::WAYS; w++) begin : g_alloc_chk
        assert property (@(posedge clock) disable iff (reset)
            fire[w] |-> spec_free[alloc_phys[w]])
            else $error("free_list: way %0d fired on a busy register", w);
    end

    // a displaced mapping was live, so it cannot sit in the pool
    for (genvar c = 0; c < rename_pkg::WAYS; c++) begin : g_release_chk
        assert property (@(posedge clock) disable iff (reset)
            commit[c].en |-> !spec_free[released_phys[c]])
            else $error("free_list: commit way %0d releases a free register", c);
    end

endmodule

// ==== hw/ready_table.sv ====
// ##################################################
// ready bit per physical register, source lookup
// and result broadcast wakeup
// ##################################################

module ready_table (
    input  logic                                         clock,
    input  logic                                         reset,
    input  logic                                         flush,
    input  rename_pkg::phys_reg_t [rename_pkg::WAYS-1:0] src_a_phys,
    input  rename_pkg::phys_reg_t [rename_pkg::WAYS-1:0] src_b_phys,
    input  logic                  [rename_pkg::WAYS-1:0] src_a_fwd,
    input  logic                  [rename_pkg::WAYS-1:0] src_b_fwd,
    input  logic                  [rename_pkg::WAYS-1:0] fire,
    input  rename_pkg::phys_reg_t [rename_pkg::WAYS-1:0] alloc_phys,
    input  rename_pkg::cdb_t      [rename_pkg::WAYS-1:0] cdb,
    output logic                  [rename_pkg::WAYS-1:0] src_a_ready,
    output logic                  [rename_pkg::WAYS-1:0] src_b_ready
);

    rename_pkg::phys_mask_t ready;
    rename_pkg::phys_mask_t ready_next;

    // registered bits only, this cycle's broadcasts show next cycle
    always_comb begin
        for (int w = 0; w < rename_pkg::WAYS; w++) begin
            src_a_ready[w] = ready[src_a_phys[w]] && !src_a_fwd[w];
            src_b_ready[w] = ready[src_b_phys[w]] && !src_b_fwd[w];
        end
    end

    always_comb begin
        ready_next = ready;
        for (int w = 0; w < rename_pkg::WAYS; w++) begin
            if (fire[w]) begin
                ready_next[alloc_phys[w]] = 1'b0;   // result pending
            end
        end
        for (int c = 0; c < rename_pkg::WAYS; c++) begin
            if (cdb[c].en) begin
                ready_next[cdb[c].phys] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity-mapped registers hold values
            ready <= ~({rename_pkg::PHYS_REGS{1'b1}} << rename_pkg::ARCH_REGS);
        end else if (flush) begin
            ready <= '1;   // nothing left in flight
        end else begin
            ready <= ready_next;
        end
    end

    // a register being allocated cannot also have a result in flight
    for (genvar c = 0; c < rename_pkg::WAYS; c++) begin : g_cdb_chk
        for (genvar w = 0; w < rename_pkg::WAYS; w++) begin : g_way
            assert property (@(posedge clock) disable iff (reset)
                (cdb[c].en && fire[w]) |-> (cdb[c].phys != alloc_phys[w]))
                else $error("ready_table: cdb %0d hits allocation of way %0d", c, w);
        end
    end

endmodule

// ==== hw/rename_map.sv ====
// ##################################################
// speculative and committed register map tables with
// in-group forwarding and single-cycle flush restore
// ##################################################

module rename_map (
    input  logic                                           clock,
    input  logic                                           reset,
    input  logic                                           flush,
    input  rename_pkg::rename_req_t [rename_pkg::WAYS-1:0] req,
    input  logic                    [rename_pkg::WAYS-1:0] fire,
    input  rename_pkg::phys_reg_t   [rename_pkg::WAYS-1:0] alloc_phys,
    input  rename_pkg::commit_t     [rename_pkg::WAYS-1:0] commit,
    output rename_pkg::phys_reg_t   [rename_pkg::WAYS-1:0] src_a_phys,
    output rename_pkg::phys_reg_t   [rename_pkg::WAYS-1:0] src_b_phys,
    output logic                    [rename_pkg::WAYS-1:0] src_a_fwd,
    output logic                    [rename_pkg::WAYS-1:0] src_b_fwd,
    output rename_pkg::phys_reg_t   [rename_pkg::WAYS-1:0] released_phys
);

    rename_pkg::phys_reg_t [rename_pkg::ARCH_REGS-1:0] spec_map;
    rename_pkg::phys_reg_t [rename_pkg::ARCH_REGS-1:0] comm_map;
    rename_pkg::phys_reg_t [rename_pkg::ARCH_REGS-1:0] spec_next;
    rename_pkg::phys_reg_t [rename_pkg::ARCH_REGS-1:0] comm_next;

    // source lookup, younger ways see dests of older firing ways
    always_comb begin
        for (int w = 0; w < rename_pkg::WAYS; w++) begin
            src_a_phys[w] = spec_map[req[w].src_a];
            src_b_phys[w] = spec_map[req[w].src_b];
            src_a_fwd[w]  = 1'b0;
            src_b_fwd[w]  = 1'b0;
            // ascending order so the youngest older writer wins
            for (int j = 0; j < w; j++) begin
                if (fire[j] && (req[j].dest == req[w].src_a)) begin
                    src_a_phys[w] = alloc_phys[j];
                    src_a_fwd[w]  = 1'b1;
                end
                if (fire[j] && (req[j].dest == req[w].src_b)) begin
                    src_b_phys[w] = alloc_phys[j];
                    src_b_fwd[w]  = 1'b1;
                end
            end
        end
    end

    // speculative writes applied way by way
    always_comb begin
        spec_next = spec_map;
        for (int w = 0; w < rename_pkg::WAYS; w++) begin
            if (fire[w]) begin
                spec_next[req[w].dest] = alloc_phys[w];
            end
        end
    end

    // committed writes in program order
    always_comb begin
        comm_next = comm_map;
        for (int c = 0; c < rename_pkg::WAYS; c++) begin
            // read before this way's write, after older ways' writes
            released_phys[c] = comm_next[commit[c].arch];
            if (commit[c].en) begin
                comm_next[commit[c].arch] = commit[c].phys;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                spec_map[i] <= rename_pkg::phys_reg_t'(i);   // identity
                comm_map[i] <= rename_pkg::phys_reg_t'(i);
            end
        end else begin
            comm_map <= comm_next;
            if (flush) begin
                spec_map <= comm_next;   // includes this cycle's commits
            end else begin
                spec_map <= spec_next;
            end
        end
    end

    // two firing ways must never be handed the same register
    for (genvar w = 1; w < rename_pkg::WAYS; w++) begin : g_alloc_chk
        for (genvar j = 0; j < w; j++) begin : g_older
            assert property (@(posedge clock) disable iff (reset)
                (fire[w] && fire[j]) |-> (alloc_phys[w] != alloc_phys[j]))
                else $error("rename_map: way %0d reuses phys of way %0d", w, j);
        end
    end

endmodule

// ==== hw/rename_pkg.sv ====
// ##################################################
// rename package: widths, sizes and the structs that
// cross the rename unit boundary
// ##################################################

package rename_pkg;

    localparam int WAYS      = 2;   // instructions per rename group
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [PHYS_REGS-1:0]         phys_mask_t;   // one bit per physical reg

    // one way of a rename group
    typedef struct packed {
        logic      en;
        arch_reg_t dest;
        arch_reg_t src_a;
        arch_reg_t src_b;
    } rename_req_t;

    typedef struct packed {
        phys_reg_t dest_phys;
        phys_reg_t src_a_phys;
        logic      src_a_ready;
        phys_reg_t src_b_phys;
        logic      src_b_ready;
    } rename_rsp_t;

    // retirement, phys is the new committed mapping of arch
    typedef struct packed {
        logic      en;
        arch_reg_t arch;
        phys_reg_t phys;
    } commit_t;

    typedef struct packed {
        logic      en;
        phys_reg_t phys;
    } cdb_t;

endpackage

// ==== hw/rename_unit.sv ====
// ##################################################
// two-way register rename unit, top level
// ##################################################

module rename_unit (
    input  logic                                           clock,
    input  logic                                           reset,
    input  logic                                           rename_valid,
    input  rename_pkg::rename_req_t [rename_pkg::WAYS-1:0] rename_req,
    output logic                                           rename_ready,
    output rename_pkg::rename_rsp_t [rename_pkg::WAYS-1:0] rename_rsp,
    input  rename_pkg::cdb_t        [rename_pkg::WAYS-1:0] cdb,
    input  rename_pkg::commit_t     [rename_pkg::WAYS-1:0] commit,
    input  logic                                           flush
);

    logic [rename_pkg::WAYS-1:0] want;   // ways carrying an instruction
    logic [rename_pkg::WAYS-1:0] fire;
    logic                        has_room;

    rename_pkg::phys_reg_t [rename_pkg::WAYS-1:0] alloc_phys;
    rename_pkg::phys_reg_t [rename_pkg::WAYS-1:0] src_a_phys;
    rename_pkg::phys_reg_t [rename_pkg::WAYS-1:0] src_b_phys;
    rename_pkg::phys_reg_t [rename_pkg::WAYS-1:0] released_phys;

    logic [rename_pkg::WAYS-1:0] src_a_fwd;
    logic [rename_pkg::WAYS-1:0] src_b_fwd;
    logic [rename_pkg::WAYS-1:0] src_a_ready;
    logic [rename_pkg::WAYS-1:0] src_b_ready;

    always_comb begin
        for (int w = 0; w < rename_pkg::WAYS; w++) begin
            want[w] = rename_req[w].en;
        end
    end

    // no renaming while the tables restore
    assign rename_ready = has_room && !flush && !reset;
    assign fire         = want & {rename_pkg::WAYS{rename_valid && rename_ready}};

    rename_map i_rename_map (
        .clock         (clock),
        .reset         (reset),
        .flush         (flush),
        .req           (rename_req),
        .fire          (fire),
        .alloc_phys    (alloc_phys),
        .commit        (commit),
        .src_a_phys    (src_a_phys),
        .src_b_phys    (src_b_phys),
        .src_a_fwd     (src_a_fwd),
        .src_b_fwd     (src_b_fwd),
        .released_phys (released_phys)
    );

    free_list i_free_list (
        .clock         (clock),
        .reset         (reset),
        .flush         (flush),
        .want          (want),
        .fire          (fire),
        .commit        (commit),
        .released_phys (released_phys),
        .alloc_phys    (alloc_phys),
        .has_room      (has_room)
    );

    ready_table i_ready_table (
        .clock       (clock),
        .reset       (reset),
        .flush       (flush),
        .src_a_phys  (src_a_phys),
        .src_b_phys  (src_b_phys),
        .src_a_fwd   (src_a_fwd),
        .src_b_fwd   (src_b_fwd),
        .fire        (fire),
        .alloc_phys  (alloc_phys),
        .cdb         (cdb),
        .src_a_ready (src_a_ready),
        .src_b_ready (src_b_ready)
    );

    always_comb begin
        for (int w = 0; w < rename_pkg::WAYS; w++) begin
            rename_rsp[w].dest_phys   = alloc_phys[w];
            rename_rsp[w].src_a_phys  = src_a_phys[w];
            rename_rsp[w].src_a_ready = src_a_ready[w];
            rename_rsp[w].src_b_phys  = src_b_phys[w];
            rename_rsp[w].src_b_ready = src_b_ready[w];
        end
    end

endmodule

// ==== rename_unit.f ====
+incdir+verif
hw/rename_pkg.sv
hw/rename_map.sv
hw/free_list.sv
hw/ready_table.sv
hw/rename_unit.sv
verif/tb_rename_unit.sv

// ==== verif/rename_ref_model.svh ====
// ##################################################
// reference model of the rename unit: map tables,
// free pool, ready bits and in-flight renames
// ##################################################
`ifndef RENAME_REF_MODEL_SVH
`define RENAME_REF_MODEL_SVH

typedef struct packed {
    rename_pkg::arch_reg_t arch;
    rename_pkg::phys_reg_t phys;
    logic                  done;   // result already broadcast
} flight_t;

rename_pkg::phys_reg_t  m_spec [rename_pkg::ARCH_REGS];
rename_pkg::phys_reg_t  m_comm [rename_pkg::ARCH_REGS];
rename_pkg::phys_mask_t m_free;
rename_pkg::phys_mask_t m_ready;
flight_t                inflight [$];   // oldest at the front

function automatic void model_reset();
    for (int p = 0; p < rename_pkg::PHYS_REGS; p++) begin
        m_free[p]  = (p >= rename_pkg::ARCH_REGS);
        m_ready[p] = (p < rename_pkg::ARCH_REGS);
    end
    for (int a = 0; a < rename_pkg::ARCH_REGS; a++) begin
        m_spec[a] = rename_pkg::phys_reg_t'(a);
        m_comm[a] = rename_pkg::phys_reg_t'(a);
    end
    inflight.delete();
endfunction

// expected handshake and responses for one cycle
function automatic void model_expect(
    input  logic                                           valid,
    input  logic                                           flushing,
    input  rename_pkg::rename_req_t [rename_pkg::WAYS-1:0] req,
    output logic                                           rdy,
    output logic                    [rename_pkg::WAYS-1:0] fired,
    output rename_pkg::rename_rsp_t [rename_pkg::WAYS-1:0] rsp
);
    rename_pkg::phys_mask_t pool;
    int                     need;
    pool = m_free;
    need = 0;
    for (int w = 0; w < rename_pkg::WAYS; w++) begin
        need += int'(req[w].en);
    end
    rdy = ($countones(m_free) >= need) && !flushing;
    for (int w = 0; w < rename_pkg::WAYS; w++) begin
        fired[w] = valid && rdy && req[w].en;
        rsp[w]   = '0;
        if (req[w].en) begin
            for (int p = 0; p < rename_pkg::PHYS_REGS; p++) begin
                if (pool[p]) begin
                    rsp[w].dest_phys = rename_pkg::phys_reg_t'(p);   // lowest free first
                    break;
                end
            end
            pool[rsp[w].dest_phys] = 1'b0;
        end
        rsp[w].src_a_phys  = m_spec[req[w].src_a];
        rsp[w].src_a_ready = m_ready[rsp[w].src_a_phys];
        rsp[w].src_b_phys  = m_spec[req[w].src_b];
        rsp[w].src_b_ready = m_ready[rsp[w].src_b_phys];
        for (int j = 0; j < w; j++) begin
            if (fired[j] && req[j].dest == req[w].src_a) begin
                rsp[w].src_a_phys  = rsp[j].dest_phys;
                rsp[w].src_a_ready = 1'b0;
            end
            if (fired[j] && req[j].dest == req[w].src_b) begin
                rsp[w].src_b_phys  = rsp[j].dest_phys;
                rsp[w].src_b_ready = 1'b0;
            end
        end
    end
endfunction

// state change at the next rising edge
function automatic void model_step(
    input logic                    [rename_pkg::WAYS-1:0] fired,
    input rename_pkg::rename_req_t [rename_pkg::WAYS-1:0] req,
    input rename_pkg::rename_rsp_t [rename_pkg::WAYS-1:0] rsp,
    input rename_pkg::cdb_t        [rename_pkg::WAYS-1:0] bcast,
    input rename_pkg::commit_t     [rename_pkg::WAYS-1:0] retire,
    input logic                                           flushing
);
    rename_pkg::phys_reg_t old;
    for (int w = 0; w < rename_pkg::WAYS; w++) begin
        if (fired[w]) begin
            m_spec[req[w].dest]      = rsp[w].dest_phys;
            m_free[rsp[w].dest_phys]  = 1'b0;
            m_ready[rsp[w].dest_phys] = 1'b0;
            inflight.push_back(flight_t'{req[w].dest, rsp[w].dest_phys, 1'b0});
        end
    end
    for (int c = 0; c < rename_pkg::WAYS; c++) begin
        if (bcast[c].en) begin
            m_ready[bcast[c].phys] = 1'b1;
        end
    end
    for (int c = 0; c < rename_pkg::WAYS; c++) begin
        if (retire[c].en) begin
            old                  = m_comm[retire[c].arch];   // displaced mapping
            m_comm[retire[c].arch] = retire[c].phys;
            m_free[old]          = 1'b1;
            void'(inflight.pop_front());
        end
    end
    if (flushing) begin
        m_ready = '1;
        m_free  = '1;
        inflight.delete();
        for (int a = 0; a < rename_pkg::ARCH_REGS; a++) begin
            m_spec[a]         = m_comm[a];
            m_free[m_comm[a]] = 1'b0;
        end
    end
endfunction

`endif

// ==== verif/tb_rename_unit.sv ====
// ##################################################
// testbench for the two-way rename unit, random and
// directed groups checked against a reference model
// ##################################################

module tb_rename_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RANDOM_CYCLES = 2000;
    localparam int TOTAL_CYCLES  = RANDOM_CYCLES + 300;   // reset and directed phases

    logic clock = 1'b0;
    logic reset;
    logic rename_valid;
    logic rename_ready;
    logic flush;
    rename_pkg::rename_req_t [rename_pkg::WAYS-1:0] rename_req;
    rename_pkg::rename_rsp_t [rename_pkg::WAYS-1:0] rename_rsp;
    rename_pkg::cdb_t        [rename_pkg::WAYS-1:0] cdb;
    rename_pkg::commit_t     [rename_pkg::WAYS-1:0] commit;

    // stimulus for the coming cycle
    logic                                           n_valid;
    logic                                           n_flush;
    rename_pkg::rename_req_t [rename_pkg::WAYS-1:0] n_req;
    rename_pkg::cdb_t        [rename_pkg::WAYS-1:0] n_cdb;
    rename_pkg::commit_t     [rename_pkg::WAYS-1:0] n_commit;

    logic [31:0] lcg_state = 32'hea8b;

    `include "rename_ref_model.svh"

    rename_unit i_dut (
        .clock        (clock),
        .reset        (reset),
        .rename_valid (rename_valid),
        .rename_req   (rename_req),
        .rename_ready (rename_ready),
        .rename_rsp   (rename_rsp),
        .cdb          (cdb),
        .commit       (commit),
        .flush        (flush)
    );

    always #10 clock = ~clock;

    function automatic int rand_below(input int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[30:8]) % n;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("error: %s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_phys(input string name, input rename_pkg::phys_reg_t expected,
                              input rename_pkg::phys_reg_t actual);
        if (actual !== expected) begin
            $display("mismatch in %s: phys expected %0d, actual %0d", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_ready(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch in %s: ready expected %0b, actual %0b", name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_handshake(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch in %s: rename_ready expected %0b, actual %0b",
                     name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic clear_stim();
        n_valid  = 1'b0;
        n_flush  = 1'b0;
        n_req    = '0;
        n_cdb    = '0;
        n_commit = '0;
    endtask

    // random group, plus legal broadcasts and in-order commits when retiring
    task automatic gen_stim(input int valid_pct, input bit both_en, input bit retire,
                            input int flush_pct);
        int start;
        int j;
        clear_stim();
        n_valid = rand_below(100) < valid_pct;
        for (int w = 0; w < rename_pkg::WAYS; w++) begin
            n_req[w].en    = both_en || (rand_below(4) != 0);
            n_req[w].dest  = rename_pkg::arch_reg_t'(rand_below(rename_pkg::ARCH_REGS));
            n_req[w].src_a = rename_pkg::arch_reg_t'(rand_below(rename_pkg::ARCH_REGS));
            n_req[w].src_b = rename_pkg::arch_reg_t'(rand_below(rename_pkg::ARCH_REGS));
        end
        if (retire) begin
            for (int c = 0; c < rename_pkg::WAYS; c++) begin
                if (inflight.size() > c && inflight[c].done && (c == 0 || n_commit[c-1].en)
                    && rand_below(4) != 0) begin
                    n_commit[c] = '{1'b1, inflight[c].arch, inflight[c].phys};
                end
            end
            for (int c = 0; c < rename_pkg::WAYS; c++) begin
                if (inflight.size() != 0 && rand_below(2) == 0) begin
                    start = rand_below(inflight.size());
                    for (int k = 0; k < inflight.size(); k++) begin
                        j = (start + k) % inflight.size();
                        if (!inflight[j].done) begin
                            inflight[j].done = 1'b1;
                            n_cdb[c] = '{1'b1, inflight[j].phys};
                            break;
                        end
                    end
                end
            end
        end
        n_flush = rand_below(100) < flush_pct;
    endtask

    // drive at the rising edge, compare at the falling edge, then advance the model
    task automatic run_cycle(input string name);
        logic                                           exp_rdy;
        logic                    [rename_pkg::WAYS-1:0] fired;
        rename_pkg::rename_rsp_t [rename_pkg::WAYS-1:0] exp;
        @(posedge clock);
        rename_valid <= n_valid;
        rename_req   <= n_req;
        cdb          <= n_cdb;
        commit       <= n_commit;
        flush        <= n_flush;
        @(negedge clock);
        model_expect(n_valid, n_flush, n_req, exp_rdy, fired, exp);
        check_handshake(name, exp_rdy, rename_ready);
        for (int w = 0; w < rename_pkg::WAYS; w++) begin
            if (n_req[w].en) begin
                if (fired[w]) begin
                    check_phys(name, exp[w].dest_phys, rename_rsp[w].dest_phys);
                end
                check_phys(name, exp[w].src_a_phys, rename_rsp[w].src_a_phys);
                check_ready(name, exp[w].src_a_ready, rename_rsp[w].src_a_ready);
                check_phys(name, exp[w].src_b_phys, rename_rsp[w].src_b_phys);
                check_ready(name, exp[w].src_b_ready, rename_rsp[w].src_b_ready);
            end
        end
        model_step(fired, n_req, exp, n_cdb, n_commit, n_flush);
    endtask

    initial begin
        #(TOTAL_CYCLES * 20 * 2);
        $display("error: watchdog expired before the tests finished");
        $display("Testbench failed");
        $fatal(1);
    end

    initial begin
        bit drained;
        reset        = 1'b1;
        rename_valid = 1'b0;
        rename_req   = '0;
        cdb          = '0;
        commit       = '0;
        flush        = 1'b0;
        clear_stim();
        model_reset();
        repeat (3) @(posedge clock);
        @(negedge clock);
        check_handshake("reset", 1'b0, rename_ready);
        @(posedge clock);
        reset <= 1'b0;

        // first group after reset
        n_valid  = 1'b1;
        n_req[0] = '{1'b1, 5'd1, 5'd3, 5'd4};
        n_req[1] = '{1'b1, 5'd2, 5'd5, 5'd6};
        run_cycle("reset_group");
        check_phys("reset_group", 6'd32, rename_rsp[0].dest_phys);
        check_phys("reset_group", 6'd33, rename_rsp[1].dest_phys);
        check_ready("reset_group", 1'b1, rename_rsp[1].src_b_ready);

        // broadcast wakes a later consumer
        clear_stim();
        n_valid  = 1'b1;
        n_req[0] = '{1'b1, 5'd7, 5'd0, 5'd0};
        run_cycle("wakeup_rename");
        clear_stim();
        inflight[inflight.size()-1].done = 1'b1;
        n_cdb[0] = '{1'b1, inflight[inflight.size()-1].phys};
        run_cycle("wakeup_cdb");
        clear_stim();
        n_valid  = 1'b1;
        n_req[0] = '{1'b1, 5'd8, 5'd7, 5'd7};
        run_cycle("wakeup_use");
        check_ready("wakeup_use", 1'b1, rename_rsp[0].src_a_ready);

        repeat (RANDOM_CYCLES) begin
            gen_stim(90, 1'b0, 1'b1, 2);
            run_cycle("random");
        end

        // drain the pool with no commits, then hold the request
        drained = 1'b0;
        for (int i = 0; i < 40 && !drained; i++) begin
            gen_stim(100, 1'b1, 1'b0, 0);
            run_cycle("drain");
            drained = !rename_ready;
        end
        if (!drained) begin
            stop_with_error("free pool never ran out of registers");
        end
        repeat (4) begin
            gen_stim(100, 1'b1, 1'b0, 0);
            run_cycle("drain_hold");
        end

        for (int i = 0; i < 200 && inflight.size() != 0; i++) begin
            gen_stim(0, 1'b0, 1'b1, 0);
            run_cycle("retire");
        end
        if (inflight.size() != 0) begin
            stop_with_error("in-flight renames did not retire");
        end
        repeat (3) begin
            gen_stim(100, 1'b1, 1'b0, 0);
            run_cycle("realloc");
        end

        // flush with renames still in flight
        repeat (3) begin
            gen_stim(100, 1'b0, 1'b0, 0);
            run_cycle("flush_fill");
        end
        clear_stim();
        n_flush = 1'b1;
        run_cycle("flush");
        gen_stim(100, 1'b1, 1'b0, 0);
        run_cycle("after_flush");
        check_ready("after_flush", 1'b1, rename_rsp[0].src_a_ready);

        $display("Testbench passed");
        $finish;
    end

endmodule
